/* verilog/vlane_defines.svh */
/*
 * vector lane sizing: part width, register count, parts per register
 * and the depth of the result buffer
 */

`ifndef VLANE_DEFINES_SVH
`define VLANE_DEFINES_SVH

// width of one register part in bits, which is also the width of every RAM port
`define VLANE_PORT_W 64

// number of architectural vector registers
`define VLANE_NREGS 32

// each 256-bit register is split into this many parts
`define VLANE_PARTS 4

// entries in the result FIFO between the ALU and the writeback stage
// stall is raised at depth minus one so the fetch register always has room
`define VLANE_FIFO_DEPTH 4

`endif

/* verilog/vreg_pkg.sv */
/*
 * vector register storage types: part address, part data, byte enables
 * and the bundle that drives one RAM write port
 */

`include "vlane_defines.svh"

package vreg_pkg;

    // part address is the register index in the upper bits and the part index below
    typedef logic [$clog2(`VLANE_NREGS * `VLANE_PARTS)-1:0] vreg_addr_t;

    // one part of a vector register
    typedef logic [`VLANE_PORT_W-1:0] vreg_data_t;

    // one enable per byte of a part
    typedef logic [`VLANE_PORT_W/8-1:0] vreg_be_t;

    // everything a single write port needs in one cycle
    typedef struct packed {
        logic       we;
        vreg_addr_t addr;
        vreg_be_t   be;
        vreg_data_t data;
    } vreg_wr_t;

endpackage

/* verilog/valu_pkg.sv */
/*
 * vector ALU types: operation and element width encodings, the command
 * issued to the fetch stage and the result it hands to writeback
 */

package valu_pkg;

    // element-wise operations, MOVE copies source 1 unchanged
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        MOVE = 3'd5
    } valu_op_e;

    // selected element width, carries and borrows stop at these boundaries
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } valu_sew_e;

    // one ALU command on a single register part
    // src1 is the minuend for SUB and the source for MOVE
    typedef struct packed {
        valu_op_e             op;
        valu_sew_e            sew;
        vreg_pkg::vreg_addr_t dst;
        vreg_pkg::vreg_addr_t src1;
        vreg_pkg::vreg_addr_t src2;
    } valu_cmd_t;

    // finished result waiting in the FIFO for write port 0
    typedef struct packed {
        vreg_pkg::vreg_addr_t addr;
        vreg_pkg::vreg_data_t data;
    } valu_res_t;

endpackage

/* verilog/vreg_xor_ram.sv */
/*
 * XOR-based multi-ported register file RAM: any number of write ports with
 * byte enables and combinational read ports built from 1W banks
 */

`timescale 1ns/1ps

`include "vlane_defines.svh"

module vreg_xor_ram #(
    parameter int unsigned PORTS_RD = 3,
    parameter int unsigned PORTS_WR = 2
) (
    input  logic                 clk_i,
    input  vreg_pkg::vreg_wr_t   wr_i      [PORTS_WR],
    input  vreg_pkg::vreg_addr_t rd_addr_i [PORTS_RD],
    output vreg_pkg::vreg_data_t rd_data_o [PORTS_RD]
);

    localparam int unsigned DEPTH  = `VLANE_NREGS * `VLANE_PARTS;
    localparam int unsigned NBYTES = `VLANE_PORT_W / 8;

    // each row owns one column per read port and one loopback column per other write port
    localparam int unsigned NCOLS = PORTS_RD + PORTS_WR - 1;

    vreg_pkg::vreg_addr_t col_addr [PORTS_WR][NCOLS];
    vreg_pkg::vreg_data_t col_data [PORTS_WR][NCOLS];
    vreg_pkg::vreg_data_t wr_data  [PORTS_WR];

    // column addressing is the same in every row for the read columns
    // loopback column k of row r serves write port k, or k+1 once k reaches r,
    // because a row never needs to read back its own write address
    always_comb begin
        for (int r = 0; r < PORTS_WR; r++) begin
            for (int c = 0; c < PORTS_RD; c++) begin
                col_addr[r][c] = rd_addr_i[c];
            end
            for (int k = 0; k < PORTS_WR - 1; k++) begin
                col_addr[r][PORTS_RD+k] = (k < r) ? wr_i[k].addr : wr_i[k+1].addr;
            end
        end
    end

    // a write stores its data XORed with what every other row holds at that address,
    // so that the XOR over all rows yields the new data on the next read
    always_comb begin
        for (int w = 0; w < PORTS_WR; w++) begin
            wr_data[w] = wr_i[w].data;
            for (int r = 0; r < PORTS_WR; r++) begin
                if (r != w) begin
                    // row r reads address w in loopback column w, or w-1 past the diagonal
                    wr_data[w] = wr_data[w] ^ col_data[r][PORTS_RD + ((w < r) ? w : w - 1)];
                end
            end
        end
    end

    // one bank per row and column, all banks of a row take the same write
    for (genvar gw = 0; gw < PORTS_WR; gw++) begin : g_row
        for (genvar gc = 0; gc < NCOLS; gc++) begin : g_col
            vreg_pkg::vreg_data_t mem_q [DEPTH];

            // byte lanes are independent in the XOR code, so a disabled byte
            // leaves the composed value of that byte untouched
            always_ff @(posedge clk_i) begin
                if (wr_i[gw].we) begin
                    for (int b = 0; b < NBYTES; b++) begin
                        if (wr_i[gw].be[b]) begin
                            mem_q[wr_i[gw].addr][b*8 +: 8] <= wr_data[gw][b*8 +: 8];
                        end
                    end
                end
            end

            // asynchronous read, a write becomes visible right after its edge
            assign col_data[gw][gc] = mem_q[col_addr[gw][gc]];
        end
    end

    // every read port XORs its own column across all rows
    always_comb begin
        for (int c = 0; c < PORTS_RD; c++) begin
            rd_data_o[c] = col_data[0][c];
            for (int r = 1; r < PORTS_WR; r++) begin
                rd_data_o[c] = rd_data_o[c] ^ col_data[r][c];
            end
        end
    end

    // the XOR code breaks if two rows update the same address at once,
    // the writeback stage has to yield to the external load for this to hold
    for (genvar ga = 0; ga < PORTS_WR; ga++) begin : g_chk_a
        for (genvar gb = ga + 1; gb < PORTS_WR; gb++) begin : g_chk_b
            a_wr_addr_conflict: assert property (@(posedge clk_i)
                (wr_i[ga].we && wr_i[gb].we) |-> (wr_i[ga].addr != wr_i[gb].addr))
                else $error("write ports %0d and %0d hit the same address", ga, gb);
        end
    end

endmodule

/* verilog/valu_fetch.sv */
/*
 * operand fetch and ALU stage: reads two source parts, computes the
 * element-wise result and registers it for the result FIFO
 */

`timescale 1ns/1ps

`include "vlane_defines.svh"

module valu_fetch (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 cmd_valid_i,
    input  valu_pkg::valu_cmd_t  cmd_i,
    output vreg_pkg::vreg_addr_t rd_addr_o [2],
    input  vreg_pkg::vreg_data_t rd_data_i [2],
    output logic                 push_o,
    output valu_pkg::valu_res_t  res_o
);

    localparam int unsigned NBYTES = `VLANE_PORT_W / 8;

    vreg_pkg::vreg_data_t result;
    logic                 valid_q;
    valu_pkg::valu_res_t  res_q;

    // true when the byte opens a new element at the given width
    function automatic logic elem_start(int unsigned idx, valu_pkg::valu_sew_e sew);
        case (sew)
            valu_pkg::SEW8:  return 1'b1;
            valu_pkg::SEW16: return (idx % 2) == 0;
            default:         return (idx % 4) == 0;
        endcase
    endfunction

    // byte-serial ripple add, the carry is reset at every element boundary
    // subtraction adds the inverted operand with a carry-in of one per element
    function automatic vreg_pkg::vreg_data_t add_sub(vreg_pkg::vreg_data_t a,
                                                     vreg_pkg::vreg_data_t b,
                                                     logic sub,
                                                     valu_pkg::valu_sew_e sew);
        vreg_pkg::vreg_data_t res;
        logic [7:0]           opb;
        logic [8:0]           sum;
        logic                 carry;
        carry = sub;
        for (int unsigned i = 0; i < NBYTES; i++) begin
            if (elem_start(i, sew)) begin
                carry = sub;
            end
            opb = sub ? ~b[i*8 +: 8] : b[i*8 +: 8];
            sum = {1'b0, a[i*8 +: 8]} + {1'b0, opb} + {8'd0, carry};
            res[i*8 +: 8] = sum[7:0];
            carry = sum[8];
        end
        return res;
    endfunction

    // sources go straight to the RAM, the data comes back in the same cycle
    assign rd_addr_o[0] = cmd_i.src1;
    assign rd_addr_o[1] = cmd_i.src2;

    always_comb begin
        case (cmd_i.op)
            valu_pkg::ADD: result = add_sub(rd_data_i[0], rd_data_i[1], 1'b0, cmd_i.sew);
            valu_pkg::SUB: result = add_sub(rd_data_i[0], rd_data_i[1], 1'b1, cmd_i.sew);
            valu_pkg::AND: result = rd_data_i[0] & rd_data_i[1];
            valu_pkg::OR:  result = rd_data_i[0] | rd_data_i[1];
            valu_pkg::XOR: result = rd_data_i[0] ^ rd_data_i[1];
            default:       result = rd_data_i[0];
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cmd_valid_i;
        end
    end

    // payload is only loaded on a strobe, valid_q tells whether it is live
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            res_q.addr <= cmd_i.dst;
            res_q.data <= result;
        end
    end

    // the push lands in the FIFO at the edge after the strobe cycle
    assign push_o = valid_q;
    assign res_o  = res_q;

    a_op_legal: assert property (@(posedge clk_i) disable iff (reset_i)
        cmd_valid_i |-> cmd_i.op inside {valu_pkg::ADD, valu_pkg::SUB, valu_pkg::AND,
                                         valu_pkg::OR, valu_pkg::XOR, valu_pkg::MOVE})
        else $error("undefined ALU operation on command strobe");

endmodule

/* verilog/valu_result_fifo.sv */
/*
 * result FIFO between ALU and writeback, a circular buffer with
 * registered empty, full and almost-full levels
 */

`timescale 1ns/1ps

`include "vlane_defines.svh"

module valu_result_fifo (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                push_i,
    input  valu_pkg::valu_res_t data_i,
    input  logic                pop_i,
    output valu_pkg::valu_res_t data_o,
    output logic                empty_o,
    output logic                full_o,
    output logic                almost_full_o
);

    localparam int unsigned DEPTH = `VLANE_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    valu_pkg::valu_res_t mem_q [DEPTH];
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [PTR_W:0]      count_q;
    logic [PTR_W:0]      count_d;

    // pointers wrap explicitly so the depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign count_d = count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            count_q       <= '0;
            empty_o       <= 1'b1;
            full_o        <= 1'b0;
            almost_full_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_d;
            // levels come from the next count so they line up with the stored entries
            empty_o       <= (count_d == '0);
            full_o        <= (count_d == (PTR_W+1)'(DEPTH));
            almost_full_o <= (count_d >= (PTR_W+1)'(DEPTH - 1));
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // head is read without a register, a new entry shows up right after its push edge
    assign data_o = mem_q[rd_ptr_q];

    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        push_i |-> !full_o) else $error("push into a full result FIFO");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
        pop_i |-> !empty_o) else $error("pop from an empty result FIFO");

endmodule

/* verilog/vreg_writeback.sv */
/*
 * writeback stage: drains the result FIFO into write port 0 and
 * steps aside for one cycle when an external load hits the same part
 */

`timescale 1ns/1ps

module vreg_writeback (
    input  logic                clk_i,
    input  logic                reset_i,
    input  valu_pkg::valu_res_t head_i,
    input  logic                empty_i,
    input  vreg_pkg::vreg_wr_t  ld_i,
    output logic                pop_o,
    output vreg_pkg::vreg_wr_t  wr_o
);

    typedef enum logic {
        RUN  = 1'b0,
        HOLD = 1'b1
    } wb_state_e;

    wb_state_e state_q;
    logic      collide;

    // a load to the head's address takes the cycle, the ALU write follows later
    // so the ALU value is the one left in the register
    assign collide = !empty_i && ld_i.we && (ld_i.addr == head_i.addr);

    assign wr_o.we   = !empty_i && !collide;
    assign wr_o.addr = head_i.addr;
    assign wr_o.be   = '1;
    assign wr_o.data = head_i.data;

    // every write retires the head entry
    assign pop_o = wr_o.we;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= RUN;
        end else if (collide) begin
            state_q <= HOLD;
        end else if (wr_o.we) begin
            state_q <= RUN;
        end
    end

    // a held entry has to stay at the head until it is written
    a_hold_keeps_head: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == HOLD) |-> (!empty_i && $stable(head_i)))
        else $error("held writeback entry left the FIFO head");

endmodule

/* verilog/vlane_top.sv */
/*
 * vector lane top: ALU fetch stage, result FIFO and writeback around a
 * 3-read, 2-write XOR register file with external load and inspection
 */

`timescale 1ns/1ps

module vlane_top (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 cmd_valid_i,
    input  valu_pkg::valu_cmd_t  cmd_i,
    input  vreg_pkg::vreg_wr_t   ld_i,
    input  vreg_pkg::vreg_addr_t rd_addr_i,
    output vreg_pkg::vreg_data_t rd_data_o,
    output logic                 stall_o,
    output logic                 idle_o
);

    vreg_pkg::vreg_addr_t fetch_rd_addr [2];
    vreg_pkg::vreg_data_t fetch_rd_data [2];
    vreg_pkg::vreg_addr_t ram_rd_addr   [3];
    vreg_pkg::vreg_data_t ram_rd_data   [3];
    vreg_pkg::vreg_wr_t   ram_wr        [2];
    vreg_pkg::vreg_wr_t   wb_wr;
    valu_pkg::valu_res_t  fetch_res;
    valu_pkg::valu_res_t  fifo_head;
    logic                 fetch_push;
    logic                 fifo_empty;
    logic                 wb_pop;

    valu_fetch i_valu_fetch (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .rd_addr_o   (fetch_rd_addr),
        .rd_data_i   (fetch_rd_data),
        .push_o      (fetch_push),
        .res_o       (fetch_res)
    );

    // almost-full doubles as the stall, one slot stays free for the fetch register
    valu_result_fifo i_valu_result_fifo (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .push_i        (fetch_push),
        .data_i        (fetch_res),
        .pop_i         (wb_pop),
        .data_o        (fifo_head),
        .empty_o       (fifo_empty),
        .full_o        (),
        .almost_full_o (stall_o)
    );

    vreg_writeback i_vreg_writeback (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .head_i  (fifo_head),
        .empty_i (fifo_empty),
        .ld_i    (ld_i),
        .pop_o   (wb_pop),
        .wr_o    (wb_wr)
    );

    // read ports 0 and 1 feed the ALU, port 2 is the inspection port
    assign ram_rd_addr[0] = fetch_rd_addr[0];
    assign ram_rd_addr[1] = fetch_rd_addr[1];
    assign ram_rd_addr[2] = rd_addr_i;
    assign fetch_rd_data[0] = ram_rd_data[0];
    assign fetch_rd_data[1] = ram_rd_data[1];
    assign rd_data_o = ram_rd_data[2];

    // write port 0 is ALU writeback, port 1 is the external load
    assign ram_wr[0] = wb_wr;
    assign ram_wr[1] = ld_i;

    vreg_xor_ram #(
        .PORTS_RD (3),
        .PORTS_WR (2)
    ) i_vreg_xor_ram (
        .clk_i     (clk_i),
        .wr_i      (ram_wr),
        .rd_addr_i (ram_rd_addr),
        .rd_data_o (ram_rd_data)
    );

    // nothing left in flight means every ALU result has reached the RAM
    assign idle_o = fifo_empty && !fetch_push;

endmodule

/* tb/tb_vlane_top.sv */
/*
 * vector lane testbench: reference model of every register part, LFSR stimulus
 * and assertion checks through the inspection port
 */

`timescale 1ns/1ps

`include "vlane_defines.svh"

module tb_vlane_top;

    localparam int unsigned NPARTS   = `VLANE_NREGS * `VLANE_PARTS;
    localparam int unsigned N_BYTE   = 16;
    localparam int unsigned N_PAIR   = 4;
    localparam int unsigned N_BURST  = 6;
    localparam int unsigned TEST_LEN = 8 + NPARTS + N_BYTE + 2 * N_PAIR + 18 + N_BURST;

    logic                 clk;
    logic                 reset;
    logic                 cmd_valid;
    valu_pkg::valu_cmd_t  cmd;
    vreg_pkg::vreg_wr_t   ld;
    vreg_pkg::vreg_addr_t rd_addr;
    vreg_pkg::vreg_data_t rd_data;
    logic                 stall;
    logic                 idle;
    logic [31:0]          lfsr_q;
    vreg_pkg::vreg_data_t model [NPARTS];
    int unsigned          value_errors;
    int unsigned          proto_errors;

    vlane_top i_vlane_top (
        .clk_i       (clk),
        .reset_i     (reset),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .ld_i        (ld),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (rd_data),
        .stall_o     (stall),
        .idle_o      (idle)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // an empty pipeline can never be asking for back-pressure
    a_idle_no_stall: assert property (@(posedge clk) disable iff (reset) idle |-> !stall)
        else begin
            proto_errors++;
            $display("stall_o is high while idle_o says the pipeline is empty");
        end

    // stall has to rise early enough that the fetch register never meets a full FIFO
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        !(i_vlane_top.fetch_push && i_vlane_top.i_valu_result_fifo.full_o))
        else begin
            proto_errors++;
            $display("a result was pushed into a full FIFO");
        end

    // on a same-address load the writeback port must stay quiet
    a_load_wins: assert property (@(posedge clk) disable iff (reset)
        (ld.we && i_vlane_top.wb_wr.we) |-> (ld.addr != i_vlane_top.wb_wr.addr))
        else begin
            proto_errors++;
            $display("writeback and external load wrote the same part in one cycle");
        end

    // Fibonacci LFSR with taps 32 22 2 1, one step per bit handed out
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] random_bits(int unsigned n);
        logic [63:0] r;
        r = '0;
        for (int unsigned i = 0; i < n; i++) begin
            r = {r[62:0], lfsr_bit()};
        end
        return r;
    endfunction

    // element-wise model, each element is cut out, computed and masked back in
    function automatic vreg_pkg::vreg_data_t expected_alu(valu_pkg::valu_cmd_t c);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] mask;
        logic [63:0] er;
        logic [63:0] res;
        int unsigned ew;
        a = model[c.src1];
        b = model[c.src2];
        ew = (c.sew == valu_pkg::SEW8) ? 8 : (c.sew == valu_pkg::SEW16) ? 16 : 32;
        mask = (64'd1 << ew) - 64'd1;
        res = '0;
        for (int unsigned e = 0; e < `VLANE_PORT_W / ew; e++) begin
            case (c.op)
                valu_pkg::ADD: er = (a >> (e * ew)) + (b >> (e * ew));
                valu_pkg::SUB: er = (a >> (e * ew)) - (b >> (e * ew));
                valu_pkg::AND: er = (a >> (e * ew)) & (b >> (e * ew));
                valu_pkg::OR:  er = (a >> (e * ew)) | (b >> (e * ew));
                valu_pkg::XOR: er = (a >> (e * ew)) ^ (b >> (e * ew));
                default:       er = a >> (e * ew);
            endcase
            res = res | ((er & mask) << (e * ew));
        end
        return res;
    endfunction

    function automatic vreg_pkg::vreg_wr_t make_load(vreg_pkg::vreg_addr_t addr, logic full);
        vreg_pkg::vreg_wr_t wr;
        wr.we   = 1'b1;
        wr.addr = addr;
        wr.be   = full ? '1 : vreg_pkg::vreg_be_t'(random_bits(8));
        wr.data = random_bits(64);
        return wr;
    endfunction

    function automatic valu_pkg::valu_cmd_t random_cmd(int unsigned op, int unsigned sew);
        valu_pkg::valu_cmd_t c;
        c.op   = valu_pkg::valu_op_e'(op);
        c.sew  = valu_pkg::valu_sew_e'(sew);
        c.dst  = vreg_pkg::vreg_addr_t'(random_bits(7));
        c.src1 = vreg_pkg::vreg_addr_t'(random_bits(7));
        c.src2 = vreg_pkg::vreg_addr_t'(random_bits(7));
        return c;
    endfunction

    // drive one load strobe and fold its enabled bytes into the model
    task automatic drive_load(vreg_pkg::vreg_wr_t wr);
        ld = wr;
        for (int b = 0; b < `VLANE_PORT_W / 8; b++) begin
            if (wr.be[b]) model[wr.addr][b*8 +: 8] = wr.data[b*8 +: 8];
        end
        @(posedge clk);
        #1;
        ld.we = 1'b0;
    endtask

    task automatic issue_cmd(valu_pkg::valu_cmd_t c);
        cmd = c;
        cmd_valid = 1'b1;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle(string name);
        int unsigned cycles;
        cycles = 0;
        while (!idle && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        a_idle_back: assert (idle)
            else begin
                proto_errors++;
                $display("%s: idle_o did not return within 50 cycles", name);
            end
    endtask

    task automatic check_part(string name, vreg_pkg::vreg_addr_t addr);
        rd_addr = addr;
        @(negedge clk);
        a_part_value: assert (rd_data === model[addr])
            else begin
                value_errors++;
                $display("Fail %s part %0d expected %h actual %h", name, addr, model[addr],
                         rd_data);
            end
        @(posedge clk);
        #1;
    endtask

    // the result reaches the writeback two cycles after its strobe, the load is timed for that
    task automatic issue_with_load(string name, valu_pkg::valu_cmd_t c, vreg_pkg::vreg_wr_t wr);
        vreg_pkg::vreg_data_t res;
        res = expected_alu(c);
        issue_cmd(c);
        @(posedge clk);
        #1;
        drive_load(wr);
        wait_idle(name);
        model[c.dst] = res;
        check_part(name, c.dst);
        check_part(name, wr.addr);
    endtask

    // a load kept on the first destination blocks the head, so the FIFO fills up
    task automatic run_burst();
        valu_pkg::valu_cmd_t  c   [N_BURST];
        vreg_pkg::vreg_data_t res [N_BURST];
        int unsigned          issued;
        int unsigned          cycles;
        logic                 stall_seen;
        for (int unsigned k = 0; k < N_BURST; k++) begin
            c[k] = random_cmd(k % 6, k % 3);
            c[k].dst  = vreg_pkg::vreg_addr_t'(64 + 9 * k);
            c[k].src1 = vreg_pkg::vreg_addr_t'(random_bits(6));
            c[k].src2 = vreg_pkg::vreg_addr_t'(random_bits(6));
            res[k] = expected_alu(c[k]);
        end
        issued = 0;
        cycles = 0;
        stall_seen = 1'b0;
        while (issued < N_BURST && cycles < 40) begin
            ld = make_load(c[0].dst, 1'b1);
            ld.we = (cycles < 10);
            if (ld.we) model[c[0].dst] = ld.data;
            stall_seen = stall_seen | stall;
            cmd = c[issued];
            cmd_valid = !stall;
            if (!stall) issued++;
            @(posedge clk);
            #1;
            cycles++;
        end
        cmd_valid = 1'b0;
        ld.we = 1'b0;
        a_burst_done: assert (issued == N_BURST && stall_seen)
            else begin
                proto_errors++;
                $display("burst issued %0d of %0d commands, stall seen %b", issued, N_BURST,
                         stall_seen);
            end
        wait_idle("burst");
        for (int unsigned k = 0; k < N_BURST; k++) begin
            model[c[k].dst] = res[k];
            check_part("burst", c[k].dst);
        end
    endtask

    initial begin
        vreg_pkg::vreg_wr_t  wr;
        valu_pkg::valu_cmd_t c;
        lfsr_q = 32'h3eb2cffd;
        value_errors = 0;
        proto_errors = 0;
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        ld = '0;
        rd_addr = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        a_reset_state: assert (!stall && idle)
            else begin
                value_errors++;
                $display("Fail reset stall/idle expected 01 actual %b%b", stall, idle);
            end
        @(posedge clk);
        #1;
        // the RAM has no reset, every part gets defined data first
        for (int a = 0; a < NPARTS; a++) begin
            drive_load(make_load(vreg_pkg::vreg_addr_t'(a), 1'b1));
        end
        for (int i = 0; i < N_BYTE; i++) begin
            wr = make_load(vreg_pkg::vreg_addr_t'(random_bits(7)), 1'b0);
            drive_load(wr);
            check_part("byte load", wr.addr);
        end
        for (int i = 0; i < N_PAIR; i++) begin
            c = random_cmd(i % 6, i % 3);
            issue_with_load("dual write", c, make_load(c.dst ^ 7'h40, 1'b0));
        end
        for (int op = 0; op < 6; op++) begin
            for (int sew = 0; sew < 3; sew++) begin
                c = random_cmd(op, sew);
                issue_cmd(c);
                wait_idle("alu");
                model[c.dst] = expected_alu(c);
                check_part({"alu ", c.op.name()}, c.dst);
            end
        end
        for (int i = 0; i < N_PAIR; i++) begin
            c = random_cmd(i + 1, i % 3);
            issue_with_load("collision", c, make_load(c.dst, 1'b0));
        end
        run_burst();
        $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TEST_LEN * 20) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+verilog
verilog/vreg_pkg.sv
verilog/valu_pkg.sv
verilog/vreg_xor_ram.sv
verilog/valu_fetch.sv
verilog/valu_result_fifo.sv
verilog/vreg_writeback.sv
verilog/vlane_top.sv
tb/tb_vlane_top.sv

/* Bender.yml */
package:
  name: vlane

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vreg_pkg.sv
      - verilog/valu_pkg.sv
      - verilog/vreg_xor_ram.sv
      - verilog/valu_fetch.sv
      - verilog/valu_result_fifo.sv
      - verilog/vreg_writeback.sv
      - verilog/vlane_top.sv
      - target: test
        files:
          - tb/tb_vlane_top.sv
